// File: list.f
rtl/pcie_symbol_pkg.sv
rtl/pcie_ltssm_pkg.sv
rtl/pcie_ts_parser.sv
rtl/pcie_ts_generator.sv
rtl/pcie_skip_inserter.sv
rtl/pcie_ltssm.sv
rtl/pcie_min_endpoint.sv
sim/tb_ts_checker.sv
sim/tb_pcie_min_endpoint.sv

// File: rtl/pcie_ltssm.sv
`timescale 1ns/1ps

module pcie_ltssm (
	input  logic                         tx_clk,
	input  logic                         rst_tx_n,
	input  logic                         ts1_strobe,
	input  logic                         ts2_strobe,
	input  logic                         link_valid,
	input  logic [4:0]                   link,
	input  logic                         lane_valid,
	input  logic [4:0]                   lane,
	input  logic                         ts_sent,
	output logic                         send_ts2,
	output logic                         tx_link_valid,
	output logic [4:0]                   tx_link,
	output logic                         tx_lane_valid,
	output logic [4:0]                   tx_lane,
	output pcie_ltssm_pkg::ltssm_state_t ltssm_state
);
	import pcie_ltssm_pkg::*;

	logic [sent_cnt_w-1:0] sent_cnt;
	logic [sent_cnt_w-1:0] sent_nx;
	logic [recv_cnt_w-1:0] recv_cnt;
	logic [recv_cnt_w-1:0] recv_nx;
	logic                  sent_inc;
	logic                  recv_inc;
	logic                  rx_ts2_pad;
	logic                  rx_ts1_link;
	logic [4:0]            cand_link;

	//////////////////////////////
	// Counter lookahead

	// Qualifying received sets per state
	assign rx_ts2_pad = ts2_strobe && !link_valid && !lane_valid;
	assign rx_ts1_link = ts1_strobe && link_valid && !lane_valid;

	// Next counts let a strobe switch state on the following edge
	always_comb begin
		sent_inc = 1'b0;
		recv_inc = 1'b0;
		case (ltssm_state)
			ltssm_polling_active: begin
				sent_inc = ts_sent && (sent_cnt < ts1_send_cnt);
				recv_inc = rx_ts2_pad && (recv_cnt < ts2_recv_cnt);
			end
			// Sent TS2s count only once the partner's TS2 is seen
			ltssm_polling_config: begin
				sent_inc = ts_sent && (recv_cnt != '0);
				recv_inc = rx_ts2_pad && (recv_cnt < ts2_recv_cnt);
			end
			default: begin
				sent_inc = 1'b0;
				recv_inc = 1'b0;
			end
		endcase
		sent_nx = sent_cnt + sent_cnt_w'(sent_inc);
		recv_nx = recv_cnt + recv_cnt_w'(recv_inc);
	end

	//////////////////////////////
	// State machine

	always_ff @(posedge tx_clk or negedge rst_tx_n) begin
		if (!rst_tx_n) begin
			ltssm_state <= ltssm_detect;
			send_ts2 <= 1'b0;
			tx_link_valid <= 1'b0;
			tx_link <= '0;
			tx_lane_valid <= 1'b0;
			tx_lane <= '0;
			sent_cnt <= '0;
			recv_cnt <= '0;
			cand_link <= '0;
		end else begin
			case (ltssm_state)
				// Receiver assumed present, leave at once
				ltssm_detect: begin
					ltssm_state <= ltssm_polling_active;
					sent_cnt <= '0;
					recv_cnt <= '0;
				end
				ltssm_polling_active: begin
					sent_cnt <= sent_nx;
					recv_cnt <= recv_nx;
					if ((sent_nx >= ts1_send_cnt) && (recv_nx >= ts2_recv_cnt)) begin
						ltssm_state <= ltssm_polling_config;
						send_ts2 <= 1'b1;
						sent_cnt <= '0;
						recv_cnt <= '0;
					end
				end
				ltssm_polling_config: begin
					sent_cnt <= sent_nx;
					recv_cnt <= recv_nx;
					if (sent_nx >= ts2_send_cnt) begin
						ltssm_state <= ltssm_cfg_lw_start;
						send_ts2 <= 1'b0;
						sent_cnt <= '0;
						recv_cnt <= '0;
					end
				end
				// Two TS1s in a row with the same link number
				ltssm_cfg_lw_start: begin
					if (rx_ts1_link) begin
						if (recv_cnt == '0) begin
							cand_link <= link;
							recv_cnt <= recv_cnt_w'(1);
						end else if (link == cand_link) begin
							tx_link <= link;
							tx_link_valid <= 1'b1;
							ltssm_state <= ltssm_cfg_lw_accept;
						end else begin
							// Newer number becomes the candidate
							cand_link <= link;
						end
					end
				end
				// Terminal; partner lane kept but still sent as PAD
				ltssm_cfg_lw_accept: begin
					if (ts1_strobe && lane_valid)
						tx_lane <= lane;
				end
				default: begin
					ltssm_state <= ltssm_detect;
				end
			endcase
		end
	end

	// Link number is advertised only from Accept onwards
	a_link_on_accept: assert property (@(posedge tx_clk) disable iff (!rst_tx_n)
		$rose(tx_link_valid) |->
			(ltssm_state == ltssm_cfg_lw_accept) && ($past(ltssm_state) == ltssm_cfg_lw_start));

endmodule

// File: rtl/pcie_ltssm_pkg.sv
package pcie_ltssm_pkg;

	//////////////////////////////
	// Link training states

	// Only the path up to Linkwidth.Accept is modelled
	typedef enum logic [2:0] {
		ltssm_detect = 3'd0,
		ltssm_polling_active = 3'd1,
		ltssm_polling_config = 3'd2,
		ltssm_cfg_lw_start = 3'd3,
		ltssm_cfg_lw_accept = 3'd4
	} ltssm_state_t;

	//////////////////////////////
	// Training count thresholds

	// TS1s sent before leaving Polling.Active
	localparam int ts1_send_min = 1024;

	// TS2s with PAD link/lane needed in Polling.Active
	localparam int ts2_recv_min = 8;

	// TS2s sent in Polling.Configuration after the first one is seen
	localparam int ts2_send_after = 16;

	// Counter widths, one spare bit so the threshold itself fits
	localparam int sent_cnt_w = $clog2(ts1_send_min) + 1;
	localparam int recv_cnt_w = $clog2(ts2_recv_min) + 1;

	// Sized copies for comparisons against the counters
	localparam logic [sent_cnt_w-1:0] ts1_send_cnt = sent_cnt_w'(ts1_send_min);
	localparam logic [sent_cnt_w-1:0] ts2_send_cnt = sent_cnt_w'(ts2_send_after);
	localparam logic [recv_cnt_w-1:0] ts2_recv_cnt = recv_cnt_w'(ts2_recv_min);

endpackage

// File: rtl/pcie_min_endpoint.sv
`timescale 1ns/1ps

module pcie_min_endpoint (
	input  logic                         tx_clk,
	input  logic                         rst_tx_n,
	input  logic [15:0]                  rx_data,
	input  logic [1:0]                   rx_charisk,
	input  logic [1:0]                   rx_err,
	output logic [15:0]                  tx_data,
	output logic [1:0]                   tx_charisk,
	output pcie_ltssm_pkg::ltssm_state_t ltssm_state
);

	//////////////////////////////
	// Receive side

	logic       ts1_strobe;
	logic       ts2_strobe;
	logic       link_valid;
	logic [4:0] link;
	logic       lane_valid;
	logic [4:0] lane;

	pcie_ts_parser u_pcie_ts_parser (
		.tx_clk     (tx_clk),
		.rst_tx_n   (rst_tx_n),
		.rx_data    (rx_data),
		.rx_charisk (rx_charisk),
		.rx_err     (rx_err),
		.ts1_strobe (ts1_strobe),
		.ts2_strobe (ts2_strobe),
		.link_valid (link_valid),
		.link       (link),
		.lane_valid (lane_valid),
		.lane       (lane)
	);

	//////////////////////////////
	// Training control

	logic       send_ts2;
	logic       tx_link_valid;
	logic [4:0] tx_link;
	logic       tx_lane_valid;
	logic [4:0] tx_lane;
	logic       ts_sent;

	pcie_ltssm u_pcie_ltssm (
		.tx_clk        (tx_clk),
		.rst_tx_n      (rst_tx_n),
		.ts1_strobe    (ts1_strobe),
		.ts2_strobe    (ts2_strobe),
		.link_valid    (link_valid),
		.link          (link),
		.lane_valid    (lane_valid),
		.lane          (lane),
		.ts_sent       (ts_sent),
		.send_ts2      (send_ts2),
		.tx_link_valid (tx_link_valid),
		.tx_link       (tx_link),
		.tx_lane_valid (tx_lane_valid),
		.tx_lane       (tx_lane),
		.ltssm_state   (ltssm_state)
	);

	//////////////////////////////
	// Transmit side

	logic [15:0] gen_data;
	logic [1:0]  gen_charisk;
	logic        skip_due;
	logic        skip_start;

	pcie_ts_generator u_pcie_ts_generator (
		.tx_clk        (tx_clk),
		.rst_tx_n      (rst_tx_n),
		.send_ts2      (send_ts2),
		.tx_link_valid (tx_link_valid),
		.tx_link       (tx_link),
		.tx_lane_valid (tx_lane_valid),
		.tx_lane       (tx_lane),
		.skip_due      (skip_due),
		.gen_data      (gen_data),
		.gen_charisk   (gen_charisk),
		.ts_sent       (ts_sent),
		.skip_start    (skip_start)
	);

	// Registered output stage with SKP substitution
	pcie_skip_inserter u_pcie_skip_inserter (
		.tx_clk      (tx_clk),
		.rst_tx_n    (rst_tx_n),
		.gen_data    (gen_data),
		.gen_charisk (gen_charisk),
		.skip_start  (skip_start),
		.skip_due    (skip_due),
		.tx_data     (tx_data),
		.tx_charisk  (tx_charisk)
	);

endmodule

// File: rtl/pcie_skip_inserter.sv
`timescale 1ns/1ps

module pcie_skip_inserter (
	input  logic        tx_clk,
	input  logic        rst_tx_n,
	input  logic [15:0] gen_data,
	input  logic [1:0]  gen_charisk,
	input  logic        skip_start,
	output logic        skip_due,
	output logic [15:0] tx_data,
	output logic [1:0]  tx_charisk
);
	import pcie_symbol_pkg::*;

	logic [skp_int_w-1:0]  interval_cnt;
	logic [skp_beat_w-1:0] skp_left;

	always_ff @(posedge tx_clk or negedge rst_tx_n) begin
		if (!rst_tx_n) begin
			interval_cnt <= '0;
			skip_due <= 1'b0;
			skp_left <= '0;
			tx_data <= 16'h0000;
			tx_charisk <= 2'b00;
		end else begin
			//////////////////////////////
			// Output select

			if (skip_start) begin
				// COM then SKP
				tx_data <= {sym_skp, sym_com};
				tx_charisk <= 2'b11;
				skp_left <= skp_last_beat;
			end else if (skp_left != '0) begin
				tx_data <= {sym_skp, sym_skp};
				tx_charisk <= 2'b11;
				skp_left <= skp_left - 1'b1;
			end else begin
				tx_data <= gen_data;
				tx_charisk <= gen_charisk;
			end

			//////////////////////////////
			// SKP interval timer

			// Restart from each SKP start, stop counting once due
			if (skip_start) begin
				interval_cnt <= '0;
				skip_due <= 1'b0;
			end else if (!skip_due) begin
				interval_cnt <= interval_cnt + 1'b1;
				skip_due <= (interval_cnt == skp_due_count);
			end
		end
	end

	// Generator must not start a SKP on its own
	a_skip_requested: assert property (@(posedge tx_clk) disable iff (!rst_tx_n)
		skip_start |-> skip_due);

endmodule

// File: rtl/pcie_symbol_pkg.sv
package pcie_symbol_pkg;

	//////////////////////////////
	// 8b10b symbol codes

	// K28.5 comma, first symbol of every ordered set
	localparam logic [7:0] sym_com = 8'hBC;

	// K23.7, marks a link or lane field as not yet assigned
	localparam logic [7:0] sym_pad = 8'hF7;

	// K28.0 filler inside a SKP ordered set
	localparam logic [7:0] sym_skp = 8'h1C;

	// D10.2 and D5.2, identifier symbols 6 to 15 of TS1 / TS2
	localparam logic [7:0] sym_ts1_id = 8'h4A;
	localparam logic [7:0] sym_ts2_id = 8'h45;

	//////////////////////////////
	// Ordered-set geometry, two symbols per beat

	localparam int ts_beats = 8;
	localparam int ts_beat_w = $clog2(ts_beats);
	localparam logic [ts_beat_w-1:0] ts_last_beat = ts_beat_w'(ts_beats - 1);

	// Beat carrying the lane symbol in its lower byte
	localparam logic [ts_beat_w-1:0] ts_lane_beat = ts_beat_w'(1);

	// First beat made of identifier symbols only
	localparam logic [ts_beat_w-1:0] ts_id_beat = ts_beat_w'(3);

	// COM + 3x SKP
	localparam int skp_beats = 2;
	localparam int skp_beat_w = $clog2(skp_beats);
	localparam logic [skp_beat_w-1:0] skp_last_beat = skp_beat_w'(skp_beats - 1);

	//////////////////////////////
	// SKP scheduling

	// Beats from one SKP start until the next one is due
	localparam int skp_interval_beats = 590;
	localparam int skp_int_w = $clog2(skp_interval_beats);
	localparam logic [skp_int_w-1:0] skp_due_count = skp_int_w'(skp_interval_beats - 1);

	// Advertised capabilities
	localparam logic [7:0] adv_num_fts = 8'd64;
	localparam logic [7:0] adv_rate_id = 8'h02;

endpackage

// File: rtl/pcie_ts_generator.sv
`timescale 1ns/1ps

module pcie_ts_generator (
	input  logic        tx_clk,
	input  logic        rst_tx_n,
	input  logic        send_ts2,
	input  logic        tx_link_valid,
	input  logic [4:0]  tx_link,
	input  logic        tx_lane_valid,
	input  logic [4:0]  tx_lane,
	input  logic        skip_due,
	output logic [15:0] gen_data,
	output logic [1:0]  gen_charisk,
	output logic        ts_sent,
	output logic        skip_start
);
	import pcie_symbol_pkg::*;

	logic [ts_beat_w-1:0]  beat;
	logic                  paused;
	logic [skp_beat_w-1:0] pause_cnt;
	logic                  ts2_q;
	logic [7:0]            lane_q;
	logic [7:0]            link_sym;
	logic [7:0]            lane_sym;
	logic [7:0]            id_sym;

	//////////////////////////////
	// Beat and pause sequencing

	// Last beat of every set
	assign ts_sent = !paused && (beat == ts_last_beat);

	// First idle beat of a pause
	assign skip_start = paused && (pause_cnt == '0);

	always_ff @(posedge tx_clk or negedge rst_tx_n) begin
		if (!rst_tx_n) begin
			beat <= '0;
			paused <= 1'b0;
			pause_cnt <= '0;
		end else if (paused) begin
			// Hold the beat counter at 0 for the SKP slot
			if (pause_cnt == skp_last_beat) begin
				paused <= 1'b0;
				pause_cnt <= '0;
			end else begin
				pause_cnt <= pause_cnt + 1'b1;
			end
		end else begin
			if (beat == ts_last_beat)
				beat <= '0;
			else
				beat <= beat + 1'b1;
			// SKP goes only between whole sets
			if (ts_sent && skip_due)
				paused <= 1'b1;
		end
	end

	// Set parameters are frozen at the set start
	always_ff @(posedge tx_clk) begin
		if (!paused && (beat == '0)) begin
			ts2_q <= send_ts2;
			lane_q <= lane_sym;
		end
	end

	//////////////////////////////
	// Symbol mux

	always_comb begin
		link_sym = tx_link_valid ? {3'b000, tx_link} : sym_pad;
		lane_sym = tx_lane_valid ? {3'b000, tx_lane} : sym_pad;
		id_sym = ts2_q ? sym_ts2_id : sym_ts1_id;
		gen_data = 16'h0000;
		gen_charisk = 2'b00;
		if (!paused) begin
			case (beat)
				// COM, link; link is taken live since beat 0 is the latch point
				3'd0: begin
					gen_data = {link_sym, sym_com};
					gen_charisk = {link_sym == sym_pad, 1'b1};
				end
				// Lane, N_FTS
				3'd1: begin
					gen_data = {adv_num_fts, lane_q};
					gen_charisk = {1'b0, lane_q == sym_pad};
				end
				// Rate ID, training control all clear
				3'd2: begin
					gen_data = {8'h00, adv_rate_id};
				end
				// Identifier fill, symbols 6..15
				default: begin
					gen_data = {id_sym, id_sym};
				end
			endcase
		end
	end

	// Set end must close a run of consecutive beats
	a_ts_sent_beat: assert property (@(posedge tx_clk) disable iff (!rst_tx_n)
		ts_sent |-> ($past(beat) == ts_last_beat - 1'b1) && !$past(paused));

endmodule

// File: rtl/pcie_ts_parser.sv
`timescale 1ns/1ps

module pcie_ts_parser (
	input  logic        tx_clk,
	input  logic        rst_tx_n,
	input  logic [15:0] rx_data,
	input  logic [1:0]  rx_charisk,
	input  logic [1:0]  rx_err,
	output logic        ts1_strobe,
	output logic        ts2_strobe,
	output logic        link_valid,
	output logic [4:0]  link,
	output logic        lane_valid,
	output logic [4:0]  lane
);
	import pcie_symbol_pkg::*;

	logic                 active;
	logic [ts_beat_w-1:0] beat;
	logic                 err;
	logic                 id_is_ts2;
	logic [7:0]           link_sym;
	logic [7:0]           lane_sym;
	logic                 com_lo;
	logic                 com_hi;
	logic                 beat_err;
	logic [7:0]           expect_id;

	//////////////////////////////
	// Per-beat checks

	always_comb begin
		com_lo = rx_charisk[0] && (rx_data[7:0] == sym_com);
		com_hi = rx_charisk[1] && (rx_data[15:8] == sym_com);
		expect_id = id_is_ts2 ? sym_ts2_id : sym_ts1_id;

		// Line errors and any COM inside a set kill it
		beat_err = (rx_err != 2'b00) || com_lo || com_hi;

		// Identifier beats are plain data, both bytes equal
		if (beat >= ts_id_beat) begin
			if ((rx_charisk != 2'b00) || (rx_data[15:8] != rx_data[7:0]))
				beat_err = 1'b1;
			// First identifier beat decides TS1 vs TS2
			if (beat == ts_id_beat) begin
				if ((rx_data[7:0] != sym_ts1_id) && (rx_data[7:0] != sym_ts2_id))
					beat_err = 1'b1;
			end else if (rx_data[7:0] != expect_id) begin
				beat_err = 1'b1;
			end
		end
	end

	//////////////////////////////
	// Set tracking

	always_ff @(posedge tx_clk or negedge rst_tx_n) begin
		if (!rst_tx_n) begin
			active <= 1'b0;
			beat <= '0;
			err <= 1'b0;
			ts1_strobe <= 1'b0;
			ts2_strobe <= 1'b0;
			link_valid <= 1'b0;
			lane_valid <= 1'b0;
		end else begin
			ts1_strobe <= 1'b0;
			ts2_strobe <= 1'b0;
			if (!active) begin
				// COM is always in the lower byte
				if (com_lo) begin
					active <= 1'b1;
					beat <= ts_lane_beat;
					err <= (rx_err != 2'b00) || com_hi;
				end
			end else begin
				err <= err || beat_err;
				if (beat == ts_last_beat) begin
					active <= 1'b0;
					beat <= '0;
					// Report only clean sets
					if (!(err || beat_err)) begin
						ts1_strobe <= !id_is_ts2;
						ts2_strobe <= id_is_ts2;
						link_valid <= (link_sym != sym_pad);
						lane_valid <= (lane_sym != sym_pad);
					end
				end else begin
					beat <= beat + 1'b1;
				end
			end
		end
	end

	// Field capture
	always_ff @(posedge tx_clk) begin
		if (!active && com_lo)
			link_sym <= rx_data[15:8];
		if (active && (beat == ts_lane_beat))
			lane_sym <= rx_data[7:0];
		if (active && (beat == ts_id_beat))
			id_is_ts2 <= (rx_data[7:0] == sym_ts2_id);
		if (active && (beat == ts_last_beat)) begin
			link <= link_sym[4:0];
			lane <= lane_sym[4:0];
		end
	end

	// One set is never both kinds
	a_one_strobe: assert property (@(posedge tx_clk) disable iff (!rst_tx_n)
		!(ts1_strobe && ts2_strobe));

endmodule

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_pcie_min_endpoint -Mdir obj_dir -f list.f \
	&& ./obj_dir/Vtb_pcie_min_endpoint | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
grep -qF '*** TEST FAILED ***' sim.log && { echo "simulation failed"; exit 1; }
grep -qF '*** TEST PASSED ***' sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"

// File: sim/pcie_ts_trace.txt
# type link_valid link lane_valid lane err_beat repeat wait_tx_ts exp_state
# err_beat 8 = clean set; state 1 active, 2 config, 3 linkwidth start, 4 accept
1 0 0 0 0 8 4 2 1
2 0 0 0 0 8 7 1030 1
2 0 0 0 0 3 1 0 1
2 1 3 0 0 8 1 0 1
2 0 0 0 0 8 1 0 2
2 0 0 0 0 8 1 0 2
1 0 0 0 0 8 2 24 3
1 1 7 1 0 8 1 0 3
1 1 5 0 0 8 1 0 3
1 1 9 0 0 8 1 0 3
1 1 9 0 0 7 1 0 3
1 1 9 0 0 8 1 0 4
1 1 9 0 0 8 2 80 4

// File: sim/tb_pcie_min_endpoint.sv
`timescale 1ns/1ps

module tb_pcie_min_endpoint;
	import pcie_symbol_pkg::*;
	import pcie_ltssm_pkg::*;

	// Cycle budget per awaited transmitted set, SKP pauses included
	localparam int tx_set_cycles = 16;
	localparam int state_wait_max = 2000;

	logic         tx_clk;
	logic         rst_tx_n;
	logic [15:0]  rx_data;
	logic [1:0]   rx_charisk;
	logic [1:0]   rx_err;
	logic [15:0]  tx_data;
	logic [1:0]   tx_charisk;
	ltssm_state_t ltssm_state;

	// Checker side
	ltssm_state_t exp_state;
	logic [4:0]   exp_link;
	logic         state_ok;
	int           ts_count;
	int           ts1_count;
	int           ts2_count;
	int           skp_count;
	int           err_count;
	int           timeout_count;
	int           missing_count;
	logic         aborted;

	always #50 tx_clk = ~tx_clk;

	pcie_min_endpoint u_pcie_min_endpoint (
		.tx_clk      (tx_clk),
		.rst_tx_n    (rst_tx_n),
		.rx_data     (rx_data),
		.rx_charisk  (rx_charisk),
		.rx_err      (rx_err),
		.tx_data     (tx_data),
		.tx_charisk  (tx_charisk),
		.ltssm_state (ltssm_state)
	);

	tb_ts_checker u_tb_ts_checker (
		.tx_clk      (tx_clk),
		.rst_tx_n    (rst_tx_n),
		.tx_data     (tx_data),
		.tx_charisk  (tx_charisk),
		.ltssm_state (ltssm_state),
		.exp_state   (exp_state),
		.exp_link    (exp_link),
		.state_ok    (state_ok),
		.ts_count    (ts_count),
		.ts1_count   (ts1_count),
		.ts2_count   (ts2_count),
		.skp_count   (skp_count),
		.err_count   (err_count)
	);

	//////////////////////////////
	// Receive stimulus

	// One 16-symbol TS as 8 beats, then a single idle beat
	task automatic send_set(input logic ts2, input int lv, input int ln, input int nv,
		input int la, input int eb);
		logic [7:0] sym [16];
		logic       isk [16];
		int         i;
		int         b;
		sym[0] = sym_com;
		isk[0] = 1'b1;
		// PAD in place of an unassigned link or lane
		sym[1] = (lv != 0) ? 8'(ln) : sym_pad;
		isk[1] = (lv == 0);
		sym[2] = (nv != 0) ? 8'(la) : sym_pad;
		isk[2] = (nv == 0);
		sym[3] = adv_num_fts;
		sym[4] = adv_rate_id;
		sym[5] = 8'h00;
		for (i = 3; i < 16; i++) begin
			if (i >= 6)
				sym[i] = ts2 ? sym_ts2_id : sym_ts1_id;
			isk[i] = 1'b0;
		end
		// Lower byte goes first on the wire
		for (b = 0; b < ts_beats; b++) begin
			@(posedge tx_clk);
			rx_data <= {sym[2*b+1], sym[2*b]};
			rx_charisk <= {isk[2*b+1], isk[2*b]};
			rx_err <= (b == eb) ? 2'b01 : 2'b00;
		end
		@(posedge tx_clk);
		rx_data <= 16'h0000;
		rx_charisk <= 2'b00;
		rx_err <= 2'b00;
	endtask

	//////////////////////////////
	// Bounded waits

	task automatic wait_tx_sets(input int n);
		int start;
		int cycles;
		start = ts_count;
		cycles = 0;
		while ((ts_count < start + n) && (cycles < n * tx_set_cycles + 64)) begin
			@(posedge tx_clk);
			cycles++;
		end
		if (ts_count < start + n) begin
			$display("timeout: waited for %0d transmitted TS, only %0d arrived",
				n, ts_count - start);
			timeout_count++;
			aborted = 1'b1;
		end
	endtask

	task automatic wait_state();
		int cycles;
		cycles = 0;
		@(posedge tx_clk);
		while (!state_ok && (cycles < state_wait_max)) begin
			@(posedge tx_clk);
			cycles++;
		end
		if (!state_ok) begin
			$display("timeout: ltssm_state stayed %s, never reached %s",
				ltssm_state.name(), exp_state.name());
			timeout_count++;
			aborted = 1'b1;
		end
	endtask

	// One trace line: wait for tx traffic, send the burst, expect a state
	task automatic run_burst(input int kind, input int lv, input int ln, input int nv,
		input int la, input int eb, input int rep, input int wait_n, input int st);
		int r;
		exp_link <= ln[4:0];
		exp_state <= ltssm_state_t'(st);
		wait_tx_sets(wait_n);
		for (r = 0; (r < rep) && !aborted; r++)
			send_set(kind == 2, lv, ln, nv, la, eb);
		// Received set end to state change is 2 cycles, plus one to sample it
		repeat (3) @(posedge tx_clk);
		if (!aborted)
			wait_state();
	endtask

	//////////////////////////////
	// Main sequence

	initial begin : main
		int    fd;
		int    n;
		string line;
		int    kind;
		int    lv;
		int    ln;
		int    nv;
		int    la;
		int    eb;
		int    rep;
		int    wait_n;
		int    st;
		tx_clk = 1'b0;
		rst_tx_n <= 1'b0;
		rx_data <= 16'h0000;
		rx_charisk <= 2'b00;
		rx_err <= 2'b00;
		exp_state <= ltssm_detect;
		exp_link <= 5'd0;
		timeout_count = 0;
		missing_count = 0;
		aborted = 1'b0;
		repeat (5) @(posedge tx_clk);
		rst_tx_n <= 1'b1;

		fd = $fopen("sim/pcie_ts_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file sim/pcie_ts_trace.txt");
			missing_count++;
			aborted = 1'b1;
		end
		while (!aborted && (fd != 0) && !$feof(fd)) begin
			n = $fgets(line, fd);
			// Comment lines start with a hash
			if ((n > 0) && (line.getc(0) != "#")) begin
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
					kind, lv, ln, nv, la, eb, rep, wait_n, st);
				if (n == 9)
					run_burst(kind, lv, ln, nv, la, eb, rep, wait_n, st);
			end
		end
		if (fd != 0)
			$fclose(fd);

		// Stream must have shown TS2 and SKP at least once
		if (ts2_count == 0) begin
			$display("no TS2 set was ever transmitted");
			missing_count++;
		end
		if (skp_count == 0) begin
			$display("no SKP ordered set was ever transmitted");
			missing_count++;
		end
		$display("summary: %0d TS1, %0d TS2, %0d SKP checked; %0d value errors, %0d timeouts, %0d other",
			ts1_count, ts2_count, skp_count, err_count, timeout_count, missing_count);
		if ((err_count == 0) && (timeout_count == 0) && (missing_count == 0))
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// File: sim/tb_ts_checker.sv
`timescale 1ns/1ps

module tb_ts_checker (
	input  logic                         tx_clk,
	input  logic                         rst_tx_n,
	input  logic [15:0]                  tx_data,
	input  logic [1:0]                   tx_charisk,
	input  pcie_ltssm_pkg::ltssm_state_t ltssm_state,
	input  pcie_ltssm_pkg::ltssm_state_t exp_state,
	input  logic [4:0]                   exp_link,
	output logic                         state_ok,
	output int                           ts_count,
	output int                           ts1_count,
	output int                           ts2_count,
	output int                           skp_count,
	output int                           err_count
);
	import pcie_symbol_pkg::*;
	import pcie_ltssm_pkg::*;

	ltssm_state_t state_d;
	logic         synced;
	logic         in_ts;
	logic         in_skp;
	int           pos;
	logic         set_ts2;
	logic         set_lv;
	int           beat_no;
	int           last_skp;

	assign state_ok = (ltssm_state == exp_state);

	//////////////////////////////
	// Reference TS symbols

	// Returns {is_k, symbol} for TS symbol idx; lane is never assigned here
	function automatic logic [8:0] ts_symbol(input int idx, input logic ts2, input logic lv,
		input logic [4:0] ln);
		case (idx)
			0: ts_symbol = {1'b1, sym_com};
			1: ts_symbol = lv ? {1'b0, 3'b000, ln} : {1'b1, sym_pad};
			2: ts_symbol = {1'b1, sym_pad};
			3: ts_symbol = {1'b0, adv_num_fts};
			4: ts_symbol = {1'b0, adv_rate_id};
			5: ts_symbol = 9'h000;
			default: ts_symbol = {1'b0, ts2 ? sym_ts2_id : sym_ts1_id};
		endcase
	endfunction

	task automatic value_error(input string name, input logic [15:0] want,
		input logic [15:0] got);
		$display("error at %0t: %s expected %h, got %h", $time, name, want, got);
		err_count++;
	endtask

	task automatic check_beat(input int p, input logic ts2, input logic lv);
		logic [8:0] lo;
		logic [8:0] hi;
		lo = ts_symbol(2 * p, ts2, lv, exp_link);
		hi = ts_symbol(2 * p + 1, ts2, lv, exp_link);
		if (tx_data !== {hi[7:0], lo[7:0]})
			value_error("tx_data", {hi[7:0], lo[7:0]}, tx_data);
		if (tx_charisk !== {hi[8], lo[8]})
			value_error("tx_charisk", {14'd0, hi[8], lo[8]}, {14'd0, tx_charisk});
	endtask

	//////////////////////////////
	// Transmit stream decoder

	// tx_data lags the generator by one cycle, so state_d is the state at set start
	always @(posedge tx_clk or negedge rst_tx_n) begin
		if (!rst_tx_n) begin
			state_d <= ltssm_detect;
			synced <= 1'b0;
			in_ts <= 1'b0;
			in_skp <= 1'b0;
			pos <= 0;
			set_ts2 <= 1'b0;
			set_lv <= 1'b0;
			beat_no <= 0;
			last_skp <= 0;
			ts_count <= 0;
			ts1_count <= 0;
			ts2_count <= 0;
			skp_count <= 0;
			err_count = 0;
		end else begin
			state_d <= ltssm_state;
			beat_no <= beat_no + 1;
			if (in_skp) begin
				// Second SKP beat
				if (tx_data !== {sym_skp, sym_skp})
					value_error("tx_data", {sym_skp, sym_skp}, tx_data);
				if (tx_charisk !== 2'b11)
					value_error("tx_charisk", 16'h0003, {14'd0, tx_charisk});
				in_skp <= 1'b0;
			end else if (in_ts) begin
				check_beat(pos, set_ts2, set_lv);
				if (pos == ts_beats - 1) begin
					in_ts <= 1'b0;
					ts_count <= ts_count + 1;
					if (set_ts2)
						ts2_count <= ts2_count + 1;
					else
						ts1_count <= ts1_count + 1;
				end else begin
					pos <= pos + 1;
				end
			end else if (tx_charisk[0] && (tx_data[7:0] == sym_com)) begin
				synced <= 1'b1;
				if (tx_data[15:8] == sym_skp) begin
					// SKP start, gap measured from the previous one
					if (tx_charisk !== 2'b11)
						value_error("tx_charisk", 16'h0003, {14'd0, tx_charisk});
					if ((skp_count > 0) && ((beat_no - last_skp < skp_interval_beats) ||
						(beat_no - last_skp > skp_interval_beats + ts_beats + skp_beats))) begin
						$display("SKP spacing wrong at %0t: %0d beats since the last SKP",
							$time, beat_no - last_skp);
						err_count++;
					end
					last_skp <= beat_no;
					skp_count <= skp_count + 1;
					in_skp <= 1'b1;
				end else begin
					// TS start, content fixed by the state at this point
					check_beat(0, state_d == ltssm_polling_config,
						state_d == ltssm_cfg_lw_accept);
					set_ts2 <= (state_d == ltssm_polling_config);
					set_lv <= (state_d == ltssm_cfg_lw_accept);
					in_ts <= 1'b1;
					pos <= 1;
				end
			end else if (synced) begin
				$display("tx stream lost alignment at %0t: %h is outside any ordered set",
					$time, tx_data);
				err_count++;
			end else begin
				// Idle output before the first set
				if (tx_data !== 16'h0000)
					value_error("tx_data", 16'h0000, tx_data);
				if (tx_charisk !== 2'b00)
					value_error("tx_charisk", 16'h0000, {14'd0, tx_charisk});
			end
		end
	end

endmodule
